/* logic/bus_hub_top.sv */
// System bus hub top joining the master port, switch, slaves, PIC and reset
`timescale 1ns/1ps
`default_nettype none

module bus_hub_top #(
  parameter int DEBOUNCE_CYCLES = 64,
  parameter int RAM_WORDS       = 256
) (
  input  logic                      clk,
  input  logic                      rst_lck,

  // Wishbone master port
  input  bus_pkg::adr_t             m_adr_i,
  input  logic                      m_tga_i,
  input  bus_pkg::data_t            m_dat_i,
  input  bus_pkg::sel_t             m_sel_i,
  input  logic                      m_we_i,
  input  logic                      m_cyc_i,
  input  logic                      m_stb_i,
  output bus_pkg::data_t            m_dat_o,
  output logic                      m_ack_o,

  // Interrupts
  input  logic                      inta_i,
  input  logic [bus_pkg::IRQ_N-1:0] irq_i,
  output logic                      intr_o,

  // Board IO
  input  logic [9:0]                sw_i,
  output logic [13:0]               leds_o
);

  // Window size follows the RAM depth
  localparam bus_pkg::map_t RAM_MASK = ~bus_pkg::map_t'(RAM_WORDS - 1);

  logic       rst;
  logic [2:0] iid;

  wb_if m_bus ();
  wb_if ram_bus ();
  wb_if gpio_bus ();

  assign m_bus.adr   = m_adr_i;
  assign m_bus.tga   = m_tga_i;
  assign m_bus.dat_w = m_dat_i;
  assign m_bus.sel   = m_sel_i;
  assign m_bus.we    = m_we_i;
  assign m_bus.cyc   = m_cyc_i;
  assign m_bus.stb   = m_stb_i;
  assign m_ack_o     = m_bus.ack;

  reset_debounce #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) reset_debounce_inst (
    .clk     (clk),
    .rst_lck (rst_lck),
    .rst_o   (rst)
  );

  bus_switch #(
    .RAM_MASK (RAM_MASK)
  ) bus_switch_inst (
    .clk     (clk),
    .rst_i   (rst),
    .m       (m_bus.slave),
    .ram     (ram_bus.master),
    .gpio    (gpio_bus.master),
    .inta_i  (inta_i),
    .iid_i   (iid),
    .m_dat_o (m_dat_o)
  );

  scratch_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) scratch_ram_inst (
    .clk   (clk),
    .rst_i (rst),
    .bus   (ram_bus.slave)
  );

  gpio_port gpio_port_inst (
    .clk    (clk),
    .rst_i  (rst),
    .bus    (gpio_bus.slave),
    .sw_i   (sw_i),
    .leds_o (leds_o)
  );

  int_ctrl int_ctrl_inst (
    .clk    (clk),
    .rst_i  (rst),
    .irq_i  (irq_i),
    .inta_i (inta_i),
    .intr_o (intr_o),
    .iid_o  (iid)
  );

endmodule

`default_nettype wire

/* logic/bus_pkg.sv */
// System bus package with widths, bus types, slave select and the address map
`default_nettype none

package bus_pkg;

  localparam int DATA_W = 16;
  localparam int SEL_W  = 2;
  localparam int ADR_W  = 19;  // Byte address bits 19..1

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [SEL_W-1:0]  sel_t;
  typedef logic [ADR_W-1:0]  adr_t;

  // IO flag on top of the word address
  typedef logic [ADR_W:0] map_t;

  // Owner of the current bus cycle
  typedef enum logic [1:0] {
    SEL_RAM,
    SEL_GPIO,
    SEL_DEFAULT
  } slave_sel_e;

  // Memory 0x00000 - 0x001ff, IO flag clear
  localparam map_t RAM_BASE  = 20'h00000;
  localparam map_t RAM_MASK  = 20'hfff00;

  // IO ports 0xf100 - 0xf103
  localparam map_t GPIO_BASE = 20'h87880;
  localparam map_t GPIO_MASK = 20'hffffe;

  // Vector returned on interrupt acknowledge is base plus id
  localparam data_t INT_VEC_BASE = 16'h0008;

  localparam int IRQ_N = 8;

endpackage

`default_nettype wire

/* logic/bus_switch.sv */
// Bus switch decoding the master cycle onto RAM, GPIO or the default slave
`timescale 1ns/1ps
`default_nettype none

module bus_switch #(
  parameter bus_pkg::map_t RAM_MASK = bus_pkg::RAM_MASK
) (
  input  logic           clk,
  input  logic           rst_i,
  wb_if.slave            m,
  wb_if.master           ram,
  wb_if.master           gpio,
  input  logic           inta_i,
  input  logic [2:0]     iid_i,
  output bus_pkg::data_t m_dat_o
);

  bus_pkg::map_t       key;
  bus_pkg::slave_sel_e slv_sel;
  logic                def_ack;

  assign key = {m.tga, m.adr};

  // RAM window has priority over GPIO
  always_comb begin
    if ((key & RAM_MASK) == (bus_pkg::RAM_BASE & RAM_MASK)) begin
      slv_sel = bus_pkg::SEL_RAM;
    end else if ((key & bus_pkg::GPIO_MASK) == bus_pkg::GPIO_BASE) begin
      slv_sel = bus_pkg::SEL_GPIO;
    end else begin
      slv_sel = bus_pkg::SEL_DEFAULT;
    end
  end

  // Shared address and write data to both slaves
  assign ram.adr    = m.adr;
  assign ram.tga    = m.tga;
  assign ram.dat_w  = m.dat_w;
  assign ram.sel    = m.sel;
  assign ram.we     = m.we;
  assign ram.cyc    = m.cyc && (slv_sel == bus_pkg::SEL_RAM);
  assign ram.stb    = m.stb && (slv_sel == bus_pkg::SEL_RAM);

  assign gpio.adr   = m.adr;
  assign gpio.tga   = m.tga;
  assign gpio.dat_w = m.dat_w;
  assign gpio.sel   = m.sel;
  assign gpio.we    = m.we;
  assign gpio.cyc   = m.cyc && (slv_sel == bus_pkg::SEL_GPIO);
  assign gpio.stb   = m.stb && (slv_sel == bus_pkg::SEL_GPIO);

  // Default slave, one cycle ack and writes dropped
  always_ff @(posedge clk) begin
    if (rst_i) begin
      def_ack <= 1'b0;
    end else begin
      def_ack <= m.cyc && m.stb && !def_ack && (slv_sel == bus_pkg::SEL_DEFAULT);
    end
  end

  assign m.ack = ram.ack | gpio.ack | def_ack;

  always_comb begin
    case (slv_sel)
      bus_pkg::SEL_RAM:  m.dat_r = ram.dat_r;
      bus_pkg::SEL_GPIO: m.dat_r = gpio.dat_r;
      default:           m.dat_r = '1;  // Unmapped reads as all ones
    endcase
  end

  // Interrupt acknowledge replaces bus data with the vector
  assign m_dat_o = inta_i ? bus_pkg::INT_VEC_BASE + bus_pkg::data_t'(iid_i) : m.dat_r;

endmodule

`default_nettype wire

/* logic/gpio_port.sv */
// GPIO slave returning the switches and holding the LED register
`timescale 1ns/1ps
`default_nettype none

module gpio_port (
  input  logic        clk,
  input  logic        rst_i,
  wb_if.slave         bus,
  input  logic [9:0]  sw_i,
  output logic [13:0] leds_o
);

  logic        access;
  logic        led_wr;
  logic [13:0] leds_q;

  assign access = bus.cyc && bus.stb && !bus.ack;
  assign led_wr = access && bus.we && bus.adr[0];  // Word 0 is read only

  always_ff @(posedge clk) begin
    if (rst_i) begin
      bus.ack <= 1'b0;
      leds_q  <= '0;
    end else begin
      bus.ack <= access;
      if (led_wr && bus.sel[0]) begin
        leds_q[7:0] <= bus.dat_w[7:0];
      end
      if (led_wr && bus.sel[1]) begin
        leds_q[13:8] <= bus.dat_w[13:8];  // Upper two bits not kept
      end
    end
  end

  // Port 0xf100 switches, port 0xf102 LEDs
  always_ff @(posedge clk) begin
    if (access) begin
      bus.dat_r <= bus.adr[0] ? {2'b00, leds_q} : {6'b000000, sw_i};
    end
  end

  assign leds_o = leds_q;

endmodule

`default_nettype wire

/* logic/int_ctrl.sv */
// Priority interrupt controller latching rising edges on the request lines
`timescale 1ns/1ps
`default_nettype none

module int_ctrl (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic [bus_pkg::IRQ_N-1:0] irq_i,
  input  logic                      inta_i,
  output logic                      intr_o,
  output logic [2:0]                iid_o
);

  logic [bus_pkg::IRQ_N-1:0] irq_q;
  logic [bus_pkg::IRQ_N-1:0] pending;
  logic [bus_pkg::IRQ_N-1:0] rise;
  logic [bus_pkg::IRQ_N-1:0] clr_mask;

  assign rise = irq_i & ~irq_q;

  // Lowest numbered line wins
  always_comb begin
    iid_o = '0;
    for (int i = bus_pkg::IRQ_N - 1; i >= 0; i--) begin
      if (pending[i]) begin
        iid_o = 3'(i);
      end
    end
  end

  always_comb begin
    clr_mask = '0;
    if (inta_i) begin
      clr_mask[iid_o] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      irq_q   <= '0;
      pending <= '0;
      intr_o  <= 1'b0;
    end else begin
      irq_q   <= irq_i;
      pending <= (pending & ~clr_mask) | rise;  // Fresh edge not lost to a clear
      intr_o  <= |pending;
    end
  end

endmodule

`default_nettype wire

/* logic/reset_debounce.sv */
// Reset debouncer holding the internal reset for a fixed time after release
`timescale 1ns/1ps
`default_nettype none

module reset_debounce #(
  parameter int DEBOUNCE_CYCLES = 64
) (
  input  logic clk,
  input  logic rst_lck,  // Raw reset, active low
  output logic rst_o
);

  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

  logic [CNT_W-1:0] cnt;

  // Any low sample on the raw reset restarts the hold time
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      cnt <= CNT_W'(DEBOUNCE_CYCLES);
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    rst_o <= !rst_lck || (cnt != '0);
  end

endmodule

`default_nettype wire

/* logic/scratch_ram.sv */
// Scratch RAM slave with per-byte write enables
`timescale 1ns/1ps
`default_nettype none

module scratch_ram #(
  parameter int RAM_WORDS = 256
) (
  input  logic clk,
  input  logic rst_i,
  wb_if.slave  bus
);

  localparam int IDX_W = $clog2(RAM_WORDS);

  bus_pkg::data_t   mem [RAM_WORDS];
  logic [IDX_W-1:0] idx;
  logic             access;

  assign idx    = bus.adr[IDX_W-1:0];
  assign access = bus.cyc && bus.stb && !bus.ack;  // New strobe, not yet acked

  always_ff @(posedge clk) begin
    if (rst_i) begin
      bus.ack <= 1'b0;
    end else begin
      bus.ack <= access;
    end
  end

  // Write lands on the edge that raises ack
  always_ff @(posedge clk) begin
    if (access && bus.we) begin
      for (int i = 0; i < bus_pkg::SEL_W; i++) begin
        if (bus.sel[i]) begin
          mem[idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      bus.dat_r <= mem[idx];
    end
  end

endmodule

`default_nettype wire

/* logic/wb_if.sv */
// Wishbone bus bundle between the hub's internal blocks
`timescale 1ns/1ps
`default_nettype none

interface wb_if;

  bus_pkg::adr_t  adr;
  logic           tga;    // High for IO cycles
  bus_pkg::data_t dat_w;
  bus_pkg::data_t dat_r;
  bus_pkg::sel_t  sel;    // Byte lanes
  logic           we;
  logic           cyc;
  logic           stb;
  logic           ack;

  modport master (
    output adr, tga, dat_w, sel, we, cyc, stb,
    input  dat_r, ack
  );

  modport slave (
    input  adr, tga, dat_w, sel, we, cyc, stb,
    output dat_r, ack
  );

endinterface

`default_nettype wire

/* sources.f */
logic/bus_pkg.sv
logic/wb_if.sv
logic/reset_debounce.sv
logic/bus_switch.sv
logic/scratch_ram.sv
logic/gpio_port.sv
logic/int_ctrl.sv
logic/bus_hub_top.sv
testbench/bus_hub_assert.sv
testbench/tb_bus_hub.sv

/* testbench/bus_hub_assert.sv */
// Bus handshake and slave select assertions bound to the bus switch
`timescale 1ns/1ps
`default_nettype none

module bus_hub_assert (
  input logic                clk,
  input logic                rst_i,
  input logic                cyc_i,
  input logic                stb_i,
  input logic                ack_i,
  input logic                ram_ack_i,
  input logic                gpio_ack_i,
  input logic                inta_i,
  input bus_pkg::slave_sel_e sel_i
);

  int fail_count = 0;

  // Ack is a single cycle pulse
  ack_single: assert property (@(posedge clk) disable iff (rst_i) ack_i |=> !ack_i)
    else begin
      $error("ack stayed high for two cycles");
      fail_count++;
    end

  ack_after_stb: assert property (@(posedge clk) disable iff (rst_i)
    (cyc_i && stb_i && !ack_i) |=> ack_i)
    else begin
      $error("strobe was not acknowledged one cycle later");
      fail_count++;
    end

  ack_in_reset: assert property (@(posedge clk) rst_i |=> !ack_i)
    else begin
      $error("ack raised while the hub was in reset");
      fail_count++;
    end

  // Vector and bus data share the read path
  inta_idle: assert property (@(posedge clk) disable iff (rst_i) !(inta_i && stb_i))
    else begin
      $error("interrupt acknowledge during an open strobe");
      fail_count++;
    end

  // Ack comes only from the slave the decoder picked
  sel_routed: assert property (@(posedge clk) disable iff (rst_i)
    (cyc_i && stb_i && !ack_i) |=>
      (ram_ack_i == ($past(sel_i) == bus_pkg::SEL_RAM)) &&
      (gpio_ack_i == ($past(sel_i) == bus_pkg::SEL_GPIO)))
    else begin
      $error("ack did not come from the selected slave");
      fail_count++;
    end

endmodule

bind bus_switch bus_hub_assert bus_hub_assert_inst (
  .clk        (clk),
  .rst_i      (rst_i),
  .cyc_i      (m.cyc),
  .stb_i      (m.stb),
  .ack_i      (m.ack),
  .ram_ack_i  (ram.ack),
  .gpio_ack_i (gpio.ack),
  .inta_i     (inta_i),
  .sel_i      (slv_sel)
);

`default_nettype wire

/* testbench/tb_bus_hub.sv */
// Testbench for the system bus hub with a reference model and compare process
`timescale 1ns/1ps
`default_nettype none

module tb_bus_hub;

  localparam int DEBOUNCE  = 16;
  localparam int RAM_TXN   = 24;
  localparam int TXN_COUNT = 2 * RAM_TXN + 40;
  localparam int ACK_LIMIT = DEBOUNCE + 8;  // Covers a strobe held across debounce
  localparam int WATCHDOG  = TXN_COUNT * 4 + DEBOUNCE + 100;

  logic           clk;
  logic           rst_lck;
  bus_pkg::adr_t  m_adr_i;
  logic           m_tga_i;
  bus_pkg::data_t m_dat_i;
  bus_pkg::sel_t  m_sel_i;
  logic           m_we_i;
  logic           m_cyc_i;
  logic           m_stb_i;
  bus_pkg::data_t m_dat_o;
  logic           m_ack_o;
  logic           inta_i;
  logic [7:0]     irq_i;
  logic           intr_o;
  logic [9:0]     sw_i;
  logic [13:0]    leds_o;

  // Reference model state
  bus_pkg::data_t model_ram [256];
  bit             ram_init [256];
  logic [13:0]    model_leds;
  logic [7:0]     model_pend;
  logic [7:0]     irq_prev;

  logic [31:0]    lfsr;
  string          cur_test;
  logic           txn_busy;
  int             err_data;
  int             err_leds;
  int             err_intr;
  int             err_other;
  int             err_assert;
  bus_pkg::adr_t  ram_adrs [RAM_TXN];

  bus_hub_top #(
    .DEBOUNCE_CYCLES (DEBOUNCE),
    .RAM_WORDS       (256)
  ) bus_hub_top_inst (
    .clk     (clk),
    .rst_lck (rst_lck),
    .m_adr_i (m_adr_i),
    .m_tga_i (m_tga_i),
    .m_dat_i (m_dat_i),
    .m_sel_i (m_sel_i),
    .m_we_i  (m_we_i),
    .m_cyc_i (m_cyc_i),
    .m_stb_i (m_stb_i),
    .m_dat_o (m_dat_o),
    .m_ack_o (m_ack_o),
    .inta_i  (inta_i),
    .irq_i   (irq_i),
    .intr_o  (intr_o),
    .sw_i    (sw_i),
    .leds_o  (leds_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  function automatic bus_pkg::data_t merge_bytes(input bus_pkg::data_t old_w,
                                                 input bus_pkg::data_t new_w,
                                                 input bus_pkg::sel_t sel);
    bus_pkg::data_t res;
    res = old_w;
    if (sel[0]) res[7:0] = new_w[7:0];
    if (sel[1]) res[15:8] = new_w[15:8];
    return res;
  endfunction

  // Expected read data from the address map
  function automatic bus_pkg::data_t ref_read(input logic tga, input bus_pkg::adr_t adr);
    logic [19:0] byte_adr;
    byte_adr = {adr, 1'b0};
    if (!tga && byte_adr < 20'h00200) begin
      return model_ram[adr[7:0]];
    end else if (tga && byte_adr >= 20'h0f100 && byte_adr <= 20'h0f103) begin
      return adr[0] ? {2'b00, model_leds} : {6'b000000, sw_i};
    end
    return 16'hffff;  // Default slave
  endfunction

  function automatic void model_write(input logic tga, input bus_pkg::adr_t adr,
                                      input bus_pkg::sel_t sel, input bus_pkg::data_t dat);
    logic [19:0]    byte_adr;
    bus_pkg::data_t led_word;
    byte_adr = {adr, 1'b0};
    if (!tga && byte_adr < 20'h00200) begin
      model_ram[adr[7:0]] = merge_bytes(model_ram[adr[7:0]], dat, sel);
    end else if (tga && byte_adr == 20'h0f102) begin
      led_word   = merge_bytes({2'b00, model_leds}, dat, sel);
      model_leds = led_word[13:0];
    end
  endfunction

  function automatic int lowest_pending();
    for (int i = 0; i < bus_pkg::IRQ_N; i++) begin
      if (model_pend[i]) return i;
    end
    return -1;
  endfunction

  function automatic void set_irq_lines(input logic [7:0] lines);
    model_pend = model_pend | (lines & ~irq_prev);  // Rising edges only
    irq_prev   = lines;
    irq_i      = lines;
  endfunction

  task automatic check_data(input string name, input bus_pkg::data_t exp,
                            input bus_pkg::data_t act);
    if (act !== exp) begin
      err_data++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_leds(input string name, input logic [13:0] exp, input logic [13:0] act);
    if (act !== exp) begin
      err_leds++;
      $display("CHECK FAILED %s leds: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_intr(input string name, input logic exp_intr, input logic act_intr,
                            input logic vec_valid, input bus_pkg::data_t exp_vec,
                            input bus_pkg::data_t act_vec);
    if (act_intr !== exp_intr) begin
      err_intr++;
      $display("CHECK FAILED %s intr: expected %b, actual %b", name, exp_intr, act_intr);
    end
    if (vec_valid && act_vec !== exp_vec) begin
      err_intr++;
      $display("CHECK FAILED %s vector: expected %h, actual %h", name, exp_vec, act_vec);
    end
  endtask

  // One Wishbone cycle, held until ack
  task automatic bus_cycle(input string name, input logic tga, input bus_pkg::adr_t adr,
                           input logic we, input bus_pkg::sel_t sel,
                           input bus_pkg::data_t dat, output int waited);
    @(negedge clk);
    cur_test = name;
    m_tga_i  = tga;
    m_adr_i  = adr;
    m_we_i   = we;
    m_sel_i  = sel;
    m_dat_i  = dat;
    m_cyc_i  = 1'b1;
    m_stb_i  = 1'b1;
    txn_busy = 1'b1;
    waited   = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!m_ack_o && waited < ACK_LIMIT);
    if (!m_ack_o) begin
      err_other++;
      $display("No acknowledge for %s within %0d cycles", name, ACK_LIMIT);
    end
    m_cyc_i = 1'b0;
    m_stb_i = 1'b0;
  endtask

  // Outputs sampled before the edge updates them
  always @(posedge clk) begin : compare_proc
    int id;
    if (m_ack_o) begin
      if (!txn_busy) begin
        err_other++;
        $display("Acknowledge seen without an open bus cycle in %s", cur_test);
      end
      txn_busy = 1'b0;
      if (m_we_i) begin
        model_write(m_tga_i, m_adr_i, m_sel_i, m_dat_i);
      end else begin
        check_data(cur_test, ref_read(m_tga_i, m_adr_i), m_dat_o);
      end
      check_leds(cur_test, model_leds, leds_o);
    end
    if (inta_i) begin
      id = lowest_pending();
      if (id < 0) begin
        err_other++;
        $display("Interrupt acknowledge in %s with nothing pending", cur_test);
      end else begin
        check_intr(cur_test, 1'b1, intr_o, 1'b1, 16'h0008 + 16'(id), m_dat_o);
        model_pend[id] = 1'b0;
      end
    end
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the tests did not complete", WATCHDOG);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    int             waited;
    int             pulses;
    logic [7:0]     pattern;
    bus_pkg::adr_t  a;
    bus_pkg::sel_t  s;
    bus_pkg::data_t d;
    rst_lck    = 1'b0;
    m_adr_i    = '0;
    m_tga_i    = 1'b0;
    m_dat_i    = '0;
    m_sel_i    = '0;
    m_we_i     = 1'b0;
    m_cyc_i    = 1'b0;
    m_stb_i    = 1'b0;
    inta_i     = 1'b0;
    irq_i      = '0;
    sw_i       = '0;
    lfsr       = 32'hb33;
    model_leds = '0;
    model_pend = '0;
    irq_prev   = '0;
    txn_busy   = 1'b0;
    cur_test   = "reset";
    err_data   = 0;
    err_leds   = 0;
    err_intr   = 0;
    err_other  = 0;
    err_assert = 0;

    repeat (5) @(negedge clk);
    rst_lck = 1'b1;
    repeat (DEBOUNCE + 4) @(negedge clk);
    if (m_ack_o !== 1'b0) begin
      err_other++;
      $display("Bus acknowledge not low after reset");
    end
    check_leds("reset", 14'h0000, leds_o);
    check_intr("reset", 1'b0, intr_o, 1'b0, 16'h0000, 16'h0000);

    // RAM byte lanes, first write to a word is full width
    for (int i = 0; i < RAM_TXN; i++) begin
      a = bus_pkg::adr_t'(rand_bits(8));
      s = bus_pkg::sel_t'(rand_bits(2));
      d = bus_pkg::data_t'(rand_bits(16));
      if (!ram_init[a[7:0]]) begin
        s = 2'b11;
        ram_init[a[7:0]] = 1'b1;
      end
      ram_adrs[i] = a;
      bus_cycle("ram_write", 1'b0, a, 1'b1, s, d, waited);
    end
    for (int i = RAM_TXN - 1; i >= 0; i--) begin
      bus_cycle("ram_read", 1'b0, ram_adrs[i], 1'b0, 2'b11, 16'h0000, waited);
    end

    // GPIO, port f100 switches and port f102 LEDs
    @(negedge clk);
    sw_i = 10'(rand_bits(10));
    bus_cycle("gpio_switches", 1'b1, 19'h07880, 1'b0, 2'b11, 16'h0000, waited);
    bus_cycle("gpio_led_low", 1'b1, 19'h07881, 1'b1, 2'b01, 16'(rand_bits(16)), waited);
    bus_cycle("gpio_led_high", 1'b1, 19'h07881, 1'b1, 2'b10, 16'(rand_bits(16)), waited);
    bus_cycle("gpio_switch_write", 1'b1, 19'h07880, 1'b1, 2'b11, 16'h3fff, waited);
    bus_cycle("gpio_led_read", 1'b1, 19'h07881, 1'b0, 2'b11, 16'h0000, waited);
    bus_cycle("gpio_switch_read", 1'b1, 19'h07880, 1'b0, 2'b11, 16'h0000, waited);

    // Unmapped windows, two of them alias RAM word 0 if decoded wrong
    bus_cycle("unmapped_prep", 1'b0, 19'h00000, 1'b1, 2'b11, 16'h5a5a, waited);
    bus_cycle("unmapped_mem_write", 1'b0, 19'h00100, 1'b1, 2'b11, 16'h1111, waited);
    bus_cycle("unmapped_io_write", 1'b1, 19'h00000, 1'b1, 2'b11, 16'h2222, waited);
    bus_cycle("unmapped_io_write", 1'b1, 19'h07883, 1'b1, 2'b11, 16'h3333, waited);
    bus_cycle("unmapped_mem_read", 1'b0, 19'h00100, 1'b0, 2'b11, 16'h0000, waited);
    bus_cycle("unmapped_mem_read", 1'b0, 19'h7ffff, 1'b0, 2'b11, 16'h0000, waited);
    bus_cycle("unmapped_io_read", 1'b1, 19'h00000, 1'b0, 2'b11, 16'h0000, waited);
    bus_cycle("unmapped_io_read", 1'b1, 19'h07882, 1'b0, 2'b11, 16'h0000, waited);
    bus_cycle("unmapped_check_ram", 1'b0, 19'h00000, 1'b0, 2'b11, 16'h0000, waited);
    bus_cycle("unmapped_check_leds", 1'b1, 19'h07881, 1'b0, 2'b11, 16'h0000, waited);

    // Several edges at once, acknowledged in priority order
    pattern = 8'(rand_bits(8)) | 8'h11;
    pulses  = $countones(pattern);
    @(negedge clk);
    set_irq_lines(pattern);
    repeat (3) @(negedge clk);
    check_intr("irq_raise", 1'b1, intr_o, 1'b0, 16'h0000, 16'h0000);
    cur_test = "irq_ack";
    repeat (pulses) begin
      inta_i = 1'b1;
      @(negedge clk);
      inta_i = 1'b0;
      @(negedge clk);
    end
    set_irq_lines(8'h00);
    repeat (3) @(negedge clk);
    check_intr("irq_drained", 1'b0, intr_o, 1'b0, 16'h0000, 16'h0000);

    // Second reset in the middle of the run
    bus_cycle("reset_led_prep", 1'b1, 19'h07881, 1'b1, 2'b11, 16'h2a5c, waited);
    @(negedge clk);
    set_irq_lines(8'h08);
    repeat (3) @(negedge clk);
    check_intr("reset_irq_prep", 1'b1, intr_o, 1'b0, 16'h0000, 16'h0000);
    rst_lck = 1'b0;
    set_irq_lines(8'h00);
    model_leds = '0;
    model_pend = '0;
    repeat (4) @(negedge clk);
    check_leds("reset_mid_run", 14'h0000, leds_o);
    check_intr("reset_mid_run", 1'b0, intr_o, 1'b0, 16'h0000, 16'h0000);
    rst_lck = 1'b1;
    bus_cycle("reset_read", 1'b0, ram_adrs[0], 1'b0, 2'b11, 16'h0000, waited);
    if (waited <= DEBOUNCE) begin
      err_other++;
      $display("Read acknowledged %0d cycles after reset release, inside debounce", waited);
    end

    repeat (2) @(negedge clk);
    err_assert = bus_hub_top_inst.bus_switch_inst.bus_hub_assert_inst.fail_count;
    $display("Errors: %0d total (data %0d, leds %0d, intr %0d, other %0d, assert %0d)",
             err_data + err_leds + err_intr + err_other + err_assert,
             err_data, err_leds, err_intr, err_other, err_assert);
    if (err_data + err_leds + err_intr + err_other + err_assert == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
